// File: hdl/msoc_pkg.sv
/*
 * shared constants and types of the peripheral subsystem
 * region map, uart register offsets, bus and fifo structs
 */
package msoc_pkg;

  ////////////////////////////////////////
  // bus and region map
  ////////////////////////////////////////
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = 4;
  localparam int REGION_LSB = 20;       // region field is addr[23:20]
  localparam int REGION_W   = 4;

  typedef enum logic [REGION_W-1:0] {
    REG_DATA_RAM  = 4'd1,
    REG_UART_CTRL = 4'd2,
    REG_UART_RX   = 4'd3,               // writes pop the rx fifo
    REG_GPIO      = 4'd7
  } region_e;

  typedef enum logic [3:0] {
    UART_TX_DATA = 4'd0,
    UART_BAUD    = 4'd1,
    UART_BREAK   = 4'd2
  } uart_reg_e;

  ////////////////////////////////////////
  // target sizes
  ////////////////////////////////////////
  localparam int RAM_WORDS     = 1024;
  localparam int RAM_AW        = 10;
  localparam int BAUD_W        = 16;
  localparam int BAUD_RESET    = 87;    // clocks per bit
  localparam int RX_FIFO_DEPTH = 16;
  localparam int RX_FIFO_AW    = 4;
  localparam int LED_W         = 8;
  localparam int DIP_W         = 16;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic       frame_err;
    logic [7:0] data;
  } rx_entry_t;

  typedef struct packed {
    logic [18:0] pad;
    logic        rx_full;
    logic        rx_frame_err;
    logic        tx_busy;
    logic        rx_busy;
    logic        rx_valid;             // fifo not empty
    logic [7:0]  rx_data;              // fifo head
  } uart_status_t;

endpackage

// File: hdl/uart_tx.sv
/*
 * baud-timed uart transmit serializer
 * 8n1 frames, lsb first, break forces the line low
 */
`timescale 1ns/10ps

module uart_tx
(
  input  logic                          msoc_clk,
  input  logic                          rstn,
  input  logic                          start_i,
  input  logic [7:0]                    byte_i,
  input  logic [msoc_pkg::BAUD_W-1:0]   baud_i,
  input  logic                          break_i,
  output logic                          tx_o,
  output logic                          busy_o
);

  typedef enum logic {
    TX_IDLE,
    TX_SHIFT
  } tx_state_e;

  tx_state_e                   state_q;
  logic [9:0]                  frame_q;         // stop, data, start
  logic [3:0]                  bit_q;
  logic [msoc_pkg::BAUD_W-1:0] baud_cnt_q;
  logic                        bit_end;

  assign bit_end = (baud_cnt_q == baud_i - 1'b1);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q    <= TX_IDLE;
      frame_q    <= '1;                         // idle line is high
      bit_q      <= '0;
      baud_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        TX_IDLE:
        begin
          if (start_i)
          begin
            frame_q    <= {1'b1, byte_i, 1'b0};
            bit_q      <= '0;
            baud_cnt_q <= '0;
            state_q    <= TX_SHIFT;
          end
        end
        TX_SHIFT:
        begin
          baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 1'b1;
          if (bit_end)
          begin
            frame_q <= {1'b1, frame_q[9:1]};    // refill with idle level
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 4'd9)
              state_q <= TX_IDLE;               // stop bit done
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  assign tx_o   = frame_q[0] & ~break_i;
  assign busy_o = (state_q == TX_SHIFT);

endmodule

// File: hdl/uart_rx.sv
/*
 * uart receive deserializer
 * three-sample majority filter, mid-bit sampling, frame error flag
 */
`timescale 1ns/10ps

module uart_rx
(
  input  logic                          msoc_clk,
  input  logic                          rstn,
  input  logic                          rx_i,
  input  logic [msoc_pkg::BAUD_W-1:0]   baud_i,
  output logic                          valid_o,
  output msoc_pkg::rx_entry_t           entry_o,
  output logic                          busy_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e                   state_q;
  logic [2:0]                  hist_q;          // last three line samples
  logic                        maj;
  logic [msoc_pkg::BAUD_W-1:0] cnt_q;
  logic [msoc_pkg::BAUD_W-1:0] lim;
  logic                        bit_end;
  logic [2:0]                  bit_q;
  logic [7:0]                  shift_q;
  logic                        valid_q;
  msoc_pkg::rx_entry_t         entry_q;

  assign maj = (hist_q[0] & hist_q[1]) | (hist_q[0] & hist_q[2]) |
               (hist_q[1] & hist_q[2]);

  // half a bit to reach the middle of the start bit
  assign lim     = (state_q == RX_START) ? (baud_i >> 1) : baud_i;
  assign bit_end = (cnt_q == lim - 1'b1);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= RX_IDLE;
      hist_q  <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      hist_q  <= {hist_q[1:0], rx_i};
      valid_q <= 1'b0;
      cnt_q   <= (state_q == RX_IDLE || bit_end) ? '0 : cnt_q + 1'b1;
      case (state_q)
        RX_IDLE:
          if (!maj)
            state_q <= RX_START;                // falling edge seen
        RX_START:
          if (bit_end)
          begin
            bit_q   <= '0;
            state_q <= maj ? RX_IDLE : RX_DATA; // glitch goes back to idle
          end
        RX_DATA:
          if (bit_end)
          begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7)
              state_q <= RX_STOP;
          end
        RX_STOP:
          if (bit_end)
          begin
            valid_q <= 1'b1;
            state_q <= RX_IDLE;
          end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (state_q == RX_DATA && bit_end)
      shift_q <= {maj, shift_q[7:1]};           // lsb first
    if (state_q == RX_STOP && bit_end)
    begin
      entry_q.data      <= shift_q;
      entry_q.frame_err <= ~maj;                // stop bit must be high
    end
  end

  assign valid_o = valid_q;
  assign entry_o = entry_q;
  assign busy_o  = (state_q != RX_IDLE);

endmodule

// File: hdl/uart_ctrl.sv
/*
 * uart register file, receive fifo and status word
 * instantiates the tx and rx serializers
 */
`timescale 1ns/10ps

module uart_ctrl
(
  input  logic                          msoc_clk,
  input  logic                          rstn,
  input  msoc_pkg::bus_req_t            bus_req_i,
  input  logic                          ctrl_sel_i,
  input  logic                          rx_sel_i,
  output logic [msoc_pkg::DATA_W-1:0]   rdata_o,
  input  logic                          uart_rx_i,
  output logic                          uart_tx_o,
  output logic                          break_o
);

  typedef logic [msoc_pkg::RX_FIFO_AW:0] ptr_t;    // extra wrap bit

  msoc_pkg::uart_reg_e          offset;
  logic                         ctrl_wr;
  logic                         tx_start;
  logic                         tx_busy;
  logic                         rx_busy;
  logic                         rx_valid;
  msoc_pkg::rx_entry_t          rx_entry;
  msoc_pkg::rx_entry_t          fifo_mem [msoc_pkg::RX_FIFO_DEPTH];
  msoc_pkg::rx_entry_t          head;
  msoc_pkg::uart_status_t       status;
  ptr_t                         wr_ptr_q;
  ptr_t                         rd_ptr_q;
  logic                         fifo_empty;
  logic                         fifo_full;
  logic                         push;
  logic                         pop;
  logic                         last_pop;
  logic [msoc_pkg::BAUD_W-1:0]  baud_q;
  logic                         break_q;
  logic                         full_q;
  logic                         frame_err_q;

  assign offset   = msoc_pkg::uart_reg_e'(bus_req_i.addr[5:2]);
  assign ctrl_wr  = ctrl_sel_i & bus_req_i.we;
  assign tx_start = ctrl_wr & (offset == msoc_pkg::UART_TX_DATA);

  uart_tx u_uart_tx (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .start_i  (tx_start),
    .byte_i   (bus_req_i.wdata[7:0]),
    .baud_i   (baud_q),
    .break_i  (break_q),
    .tx_o     (uart_tx_o),
    .busy_o   (tx_busy)
  );

  uart_rx u_uart_rx (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .rx_i     (uart_rx_i),
    .baud_i   (baud_q),
    .valid_o  (rx_valid),
    .entry_o  (rx_entry),
    .busy_o   (rx_busy)
  );

  ////////////////////////////////////////
  // receive fifo
  ////////////////////////////////////////
  assign fifo_empty = (wr_ptr_q == rd_ptr_q);
  assign fifo_full  = (wr_ptr_q[msoc_pkg::RX_FIFO_AW] != rd_ptr_q[msoc_pkg::RX_FIFO_AW]) &&
                      (wr_ptr_q[msoc_pkg::RX_FIFO_AW-1:0] == rd_ptr_q[msoc_pkg::RX_FIFO_AW-1:0]);
  assign push       = rx_valid & ~fifo_full;        // full fifo drops the byte
  assign pop        = rx_sel_i & bus_req_i.we & ~fifo_empty;
  assign last_pop   = pop & ~push & ((wr_ptr_q - rd_ptr_q) == ptr_t'(1));
  assign head       = fifo_mem[rd_ptr_q[msoc_pkg::RX_FIFO_AW-1:0]];

  always_ff @(posedge msoc_clk)
  begin
    if (push)
      fifo_mem[wr_ptr_q[msoc_pkg::RX_FIFO_AW-1:0]] <= rx_entry;
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      full_q      <= 1'b0;
      frame_err_q <= 1'b0;
      baud_q      <= msoc_pkg::BAUD_W'(msoc_pkg::BAUD_RESET);
      break_q     <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (last_pop)
      begin
        full_q      <= 1'b0;                        // sticky flags clear when drained
        frame_err_q <= 1'b0;
      end
      if (rx_valid && fifo_full)
        full_q <= 1'b1;
      if (rx_valid && rx_entry.frame_err)
        frame_err_q <= 1'b1;
      if (ctrl_wr && offset == msoc_pkg::UART_BAUD)
        baud_q <= bus_req_i.wdata[msoc_pkg::BAUD_W-1:0];
      if (ctrl_wr && offset == msoc_pkg::UART_BREAK)
        break_q <= bus_req_i.wdata[msoc_pkg::DATA_W-1];
    end
  end

  always_comb
  begin
    status              = '0;
    status.rx_full      = full_q | fifo_full;
    status.rx_frame_err = frame_err_q;
    status.tx_busy      = tx_busy;
    status.rx_busy      = rx_busy;
    status.rx_valid     = ~fifo_empty;
    status.rx_data      = head.data;
  end

  assign rdata_o = ((ctrl_sel_i | rx_sel_i) & ~bus_req_i.we) ? status : '0;
  assign break_o = break_q;

endmodule

// File: hdl/data_ram.sv
/*
 * byte-enabled single-port word ram, one-cycle read
 */
`timescale 1ns/10ps

module data_ram
(
  input  logic                          msoc_clk,
  input  msoc_pkg::bus_req_t            bus_req_i,
  input  logic                          sel_i,
  output logic [msoc_pkg::DATA_W-1:0]   rdata_o
);

  logic [msoc_pkg::DATA_W-1:0] mem [msoc_pkg::RAM_WORDS];
  logic [msoc_pkg::RAM_AW-1:0] word_addr;

  assign word_addr = bus_req_i.addr[msoc_pkg::RAM_AW+1:2];   // addr[11:2]

  always_ff @(posedge msoc_clk)
  begin
    if (sel_i)
    begin
      if (bus_req_i.we)
      begin
        for (int b = 0; b < msoc_pkg::BE_W; b++)
        begin
          if (bus_req_i.be[b])
            mem[word_addr][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
        end
      end
      rdata_o <= mem[word_addr];               // old word on a write
    end
  end

endmodule

// File: hdl/bus_ctrl.sv
/*
 * data bus handshake and region decode
 * or-style read return, led register and dip sampling
 */
`timescale 1ns/10ps

module bus_ctrl
(
  input  logic                          msoc_clk,
  input  logic                          rstn,
  input  msoc_pkg::bus_req_t            bus_req_i,
  output msoc_pkg::bus_rsp_t            bus_rsp_o,
  output logic                          ram_sel_o,
  output logic                          uart_ctrl_sel_o,
  output logic                          uart_rx_sel_o,
  input  logic [msoc_pkg::DATA_W-1:0]   ram_rdata_i,
  input  logic [msoc_pkg::DATA_W-1:0]   uart_rdata_i,
  output logic [msoc_pkg::LED_W-1:0]    led_o,
  input  logic [msoc_pkg::DIP_W-1:0]    dip_i
);

  msoc_pkg::region_e           region;
  logic                        gpio_sel;
  logic                        rd;
  logic [msoc_pkg::DATA_W-1:0] dip_word;
  logic [msoc_pkg::DATA_W-1:0] hold_d;

  logic                        rvalid_q;
  logic                        ram_rd_q;      // response comes from the ram
  logic [msoc_pkg::DATA_W-1:0] hold_q;        // captured uart/gpio word
  logic [msoc_pkg::LED_W-1:0]  led_q;
  logic [msoc_pkg::DIP_W-1:0]  dip_q;

  ////////////////////////////////////////
  // region decode
  ////////////////////////////////////////
  assign region = msoc_pkg::region_e'(
                    bus_req_i.addr[msoc_pkg::REGION_LSB +: msoc_pkg::REGION_W]);

  assign ram_sel_o       = bus_req_i.req & (region == msoc_pkg::REG_DATA_RAM);
  assign uart_ctrl_sel_o = bus_req_i.req & (region == msoc_pkg::REG_UART_CTRL);
  assign uart_rx_sel_o   = bus_req_i.req & (region == msoc_pkg::REG_UART_RX);
  assign gpio_sel        = bus_req_i.req & (region == msoc_pkg::REG_GPIO);
  assign rd              = bus_req_i.req & ~bus_req_i.we;

  assign dip_word = {{(msoc_pkg::DATA_W - msoc_pkg::DIP_W){1'b0}}, dip_q};

  // uart word is already zero unless one of its regions is read
  assign hold_d = uart_rdata_i | ({msoc_pkg::DATA_W{gpio_sel & rd}} & dip_word);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rvalid_q <= 1'b0;
      ram_rd_q <= 1'b0;
      led_q    <= '0;
      dip_q    <= '0;
    end
    else
    begin
      rvalid_q <= bus_req_i.req;                 // one cycle after grant
      ram_rd_q <= ram_sel_o & ~bus_req_i.we;
      dip_q    <= dip_i;                         // sampled every cycle
      if (gpio_sel && bus_req_i.we)
        led_q <= bus_req_i.wdata[msoc_pkg::LED_W-1:0];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (bus_req_i.req)
      hold_q <= hold_d;                          // zero for writes and holes
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////
  always_comb
  begin
    bus_rsp_o.gnt    = bus_req_i.req;            // no back-pressure
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.rdata  = ({msoc_pkg::DATA_W{ram_rd_q}} & ram_rdata_i) | hold_q;
  end

  assign led_o = led_q;

endmodule

// File: hdl/msoc_periph.sv
/*
 * peripheral subsystem top
 * bus controller, data ram and uart controller
 */
`timescale 1ns/10ps

module msoc_periph
(
  input  logic                          msoc_clk,
  input  logic                          rstn,
  input  msoc_pkg::bus_req_t            bus_req_i,
  output msoc_pkg::bus_rsp_t            bus_rsp_o,
  input  logic                          uart_rx_i,
  output logic                          uart_tx_o,
  output logic                          uart_break_o,
  output logic [msoc_pkg::LED_W-1:0]    led_o,
  input  logic [msoc_pkg::DIP_W-1:0]    dip_i
);

  logic                        ram_sel;
  logic                        uart_ctrl_sel;
  logic                        uart_rx_sel;
  logic [msoc_pkg::DATA_W-1:0] ram_rdata;
  logic [msoc_pkg::DATA_W-1:0] uart_rdata;   // combinational status word

  bus_ctrl u_bus_ctrl (
    .msoc_clk        (msoc_clk),
    .rstn            (rstn),
    .bus_req_i       (bus_req_i),
    .bus_rsp_o       (bus_rsp_o),
    .ram_sel_o       (ram_sel),
    .uart_ctrl_sel_o (uart_ctrl_sel),
    .uart_rx_sel_o   (uart_rx_sel),
    .ram_rdata_i     (ram_rdata),
    .uart_rdata_i    (uart_rdata),
    .led_o           (led_o),
    .dip_i           (dip_i)
  );

  data_ram u_data_ram (
    .msoc_clk  (msoc_clk),
    .bus_req_i (bus_req_i),
    .sel_i     (ram_sel),
    .rdata_o   (ram_rdata)
  );

  uart_ctrl u_uart_ctrl (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .bus_req_i  (bus_req_i),
    .ctrl_sel_i (uart_ctrl_sel),
    .rx_sel_i   (uart_rx_sel),
    .rdata_o    (uart_rdata),
    .uart_rx_i  (uart_rx_i),
    .uart_tx_o  (uart_tx_o),
    .break_o    (uart_break_o)
  );

endmodule

// File: bench/tb_clkgen.sv
/*
 * testbench clock source, 40 ns period
 */
`timescale 1ns/10ps

module tb_clkgen
(
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;     // half period
  end

endmodule

// File: bench/tb_msoc.sv
/*
 * testbench for the peripheral subsystem
 * lfsr stimulus, ram/led/uart model, compare tasks
 * handshake, ram, gpio, uart loopback, overflow and break tests
 */
`timescale 1ns/10ps

module tb_msoc;

  localparam int POLL_MAX = 200;                 // status polls per wait

  logic                        msoc_clk;
  logic                        rstn;
  msoc_pkg::bus_req_t          bus_req;
  msoc_pkg::bus_rsp_t          bus_rsp;
  wire                         uart_line;        // tx looped back to rx
  logic                        uart_break;
  logic [msoc_pkg::LED_W-1:0]  led;
  logic [msoc_pkg::DIP_W-1:0]  dip;

  logic [31:0]                 lfsr_q;
  int                          err_cnt;
  int                          check_cnt;
  int                          test_cnt;
  int                          test_fail;
  int                          err_base;
  logic [msoc_pkg::DATA_W-1:0] ram_model [msoc_pkg::RAM_WORDS];
  logic [7:0]                  rx_model [$];     // bytes expected in the rx fifo
  logic                        model_full;

  tb_clkgen u_clkgen (.clk_o(msoc_clk));

  msoc_periph u_msoc_periph (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .bus_req_i    (bus_req),
    .bus_rsp_o    (bus_rsp),
    .uart_rx_i    (uart_line),
    .uart_tx_o    (uart_line),
    .uart_break_o (uart_break),
    .led_o        (led),
    .dip_i        (dip)
  );

  ////////////////////////////////////////
  // stimulus and model helpers
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] region_addr(input logic [3:0] region, input logic [19:0] offs);
    return {8'h00, region, offs};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  function automatic msoc_pkg::uart_status_t expect_status(input logic valid, input logic [7:0] data,
                                                           input logic full);
    msoc_pkg::uart_status_t s;
    s          = '0;
    s.rx_valid = valid;
    s.rx_data  = data;
    s.rx_full  = full;
    return s;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_flag(input string what, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_rsp_data(input string what, input msoc_pkg::bus_rsp_t rsp,
                                input logic [msoc_pkg::DATA_W-1:0] exp);
    check_cnt++;
    if (rsp.rdata !== exp)
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", what, rsp.rdata, exp);
      err_cnt++;
    end
  endtask

  task automatic check_status(input string what, input msoc_pkg::uart_status_t got,
                              input msoc_pkg::uart_status_t exp);
    msoc_pkg::uart_status_t mask;
    mask         = '1;                           // busy bits vary with timing
    mask.tx_busy = 1'b0;
    mask.rx_busy = 1'b0;
    if (!exp.rx_valid)
      mask.rx_data = '0;
    check_cnt++;
    if ((got & mask) !== (exp & mask))
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", what, got & mask, exp & mask);
      err_cnt++;
    end
  endtask

  task automatic check_led(input string what, input logic [msoc_pkg::LED_W-1:0] got,
                           input logic [msoc_pkg::LED_W-1:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", what, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // bus access, entered 2 ns after a rising edge
  ////////////////////////////////////////
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output msoc_pkg::bus_rsp_t rsp);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.be    = be;
    #1;
    check_flag("gnt", bus_rsp.gnt, 1'b1);
    check_flag("rvalid", bus_rsp.rvalid, 1'b0);  // nothing in flight yet
    @(posedge msoc_clk);
    #2;
    bus_req = '0;
    #1;
    rsp = bus_rsp;
    check_flag("rvalid", rsp.rvalid, 1'b1);
    @(posedge msoc_clk);
    #2;
  endtask

  task automatic read_word(input logic [31:0] addr, output msoc_pkg::bus_rsp_t rsp);
    bus_access(1'b0, addr, 32'h0, 4'h0, rsp);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
    msoc_pkg::bus_rsp_t rsp;
    bus_access(1'b1, addr, data, be, rsp);
    check_rsp_data("rdata", rsp, 32'h0);         // writes return zero
  endtask

  task automatic read_status(output msoc_pkg::uart_status_t st);
    msoc_pkg::bus_rsp_t rsp;
    read_word(region_addr(msoc_pkg::REG_UART_CTRL, 20'h0), rsp);
    st = rsp.rdata;
  endtask

  task automatic pop_entry();
    write_word(region_addr(msoc_pkg::REG_UART_RX, 20'h0), 32'h0, 4'hf);
  endtask

  task automatic send_byte(input logic [7:0] b);
    msoc_pkg::uart_status_t st;
    int polls;
    write_word(region_addr(msoc_pkg::REG_UART_CTRL, {14'h0, msoc_pkg::UART_TX_DATA, 2'b00}),
               {24'h0, b}, 4'hf);
    if (rx_model.size() < msoc_pkg::RX_FIFO_DEPTH)
      rx_model.push_back(b);
    else
      model_full = 1'b1;                         // byte is dropped
    polls = 0;
    read_status(st);
    check_flag("tx_busy", st.tx_busy, 1'b1);     // frame still on the line
    while ((st.tx_busy || st.rx_busy) && polls < POLL_MAX)
    begin
      read_status(st);
      polls++;
    end
    if (st.tx_busy || st.rx_busy)
    begin
      $display("timeout: uart still busy after sending a byte");
      err_cnt++;
    end
  endtask

  task automatic wait_rx_valid(output msoc_pkg::uart_status_t st);
    int polls;
    polls = 0;
    read_status(st);
    while (!st.rx_valid && polls < POLL_MAX)
    begin
      read_status(st);
      polls++;
    end
    if (!st.rx_valid)
    begin
      $display("timeout: no received byte showed up in the uart status");
      err_cnt++;
    end
  endtask

  task automatic drain_rx();
    msoc_pkg::uart_status_t st;
    while (rx_model.size() > 0)
    begin
      wait_rx_valid(st);
      check_status("uart status", st, expect_status(1'b1, rx_model[0], model_full));
      void'(rx_model.pop_front());
      pop_entry();
    end
    model_full = 1'b0;                           // sticky flags clear once empty
    read_status(st);
    check_status("uart status", st, expect_status(1'b0, 8'h00, 1'b0));
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_base)
      $display("test %s: passed", name);
    else
    begin
      $display("test %s: %0d errors", name, err_cnt - err_base);
      test_fail++;
    end
    err_base = err_cnt;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin
    msoc_pkg::bus_rsp_t rsp;
    msoc_pkg::uart_status_t st;
    logic [msoc_pkg::RAM_AW-1:0] idx [12];
    logic [31:0] data;
    logic [3:0] be;
    logic [msoc_pkg::LED_W-1:0] led_val;
    logic [3:0] holes [3];

    lfsr_q     = 32'h78f0933d;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    test_fail  = 0;
    err_base   = 0;
    model_full = 1'b0;
    bus_req    = '0;
    dip        = '0;
    rstn       = 1'b0;
    repeat (4) @(posedge msoc_clk);
    #2;
    rstn = 1'b1;

    // handshake, reset state and unmapped regions
    check_flag("uart_tx_o", uart_line, 1'b1);
    check_flag("uart_break_o", uart_break, 1'b0);
    check_led("led_o", led, '0);
    read_status(st);
    check_flag("tx_busy", st.tx_busy, 1'b0);
    holes[0] = 4'h0;
    holes[1] = 4'h4;
    holes[2] = 4'hf;
    for (int i = 0; i < 3; i++)
    begin
      read_word(region_addr(holes[i], 20'(rand_bits(20))), rsp);
      check_rsp_data("rdata", rsp, 32'h0);
    end
    write_word(region_addr(4'h6, 20'(rand_bits(20))), rand_bits(32), 4'hf);
    end_test("handshake");

    // data ram, full write then a partial merge
    for (int i = 0; i < 12; i++)
    begin
      idx[i] = msoc_pkg::RAM_AW'(rand_bits(msoc_pkg::RAM_AW));
      data   = rand_bits(32);
      write_word(region_addr(msoc_pkg::REG_DATA_RAM, {8'h0, idx[i], 2'b00}), data, 4'hf);
      ram_model[idx[i]] = data;
      data = rand_bits(32);
      be   = 4'(rand_bits(4));
      write_word(region_addr(msoc_pkg::REG_DATA_RAM, {8'h0, idx[i], 2'b00}), data, be);
      ram_model[idx[i]] = merge_bytes(ram_model[idx[i]], data, be);
    end
    for (int i = 0; i < 12; i++)
    begin
      read_word(region_addr(msoc_pkg::REG_DATA_RAM, {8'h0, idx[i], 2'b00}), rsp);
      check_rsp_data("rdata", rsp, ram_model[idx[i]]);
    end
    end_test("data_ram");

    // gpio
    for (int i = 0; i < 4; i++)
    begin
      led_val = msoc_pkg::LED_W'(rand_bits(msoc_pkg::LED_W));
      write_word(region_addr(msoc_pkg::REG_GPIO, 20'h0), {24'h0, led_val}, 4'hf);
      check_led("led_o", led, led_val);
      dip = msoc_pkg::DIP_W'(rand_bits(msoc_pkg::DIP_W));
      @(posedge msoc_clk);                       // let the dip register sample
      #2;
      read_word(region_addr(msoc_pkg::REG_GPIO, 20'h0), rsp);
      check_rsp_data("rdata", rsp, {16'h0, dip});
    end
    end_test("gpio");

    // uart loopback at 4 clocks per bit
    write_word(region_addr(msoc_pkg::REG_UART_CTRL, {14'h0, msoc_pkg::UART_BAUD, 2'b00}),
               32'd4, 4'hf);
    for (int i = 0; i < 5; i++)
      send_byte(8'(rand_bits(8)));
    drain_rx();
    end_test("uart_loopback");

    // one byte more than the fifo holds
    for (int i = 0; i <= msoc_pkg::RX_FIFO_DEPTH; i++)
      send_byte(8'(rand_bits(8)));
    drain_rx();
    end_test("rx_overflow");

    // break holds the line low
    write_word(region_addr(msoc_pkg::REG_UART_CTRL, {14'h0, msoc_pkg::UART_BREAK, 2'b00}),
               32'h8000_0000, 4'hf);
    check_flag("uart_tx_o", uart_line, 1'b0);
    check_flag("uart_break_o", uart_break, 1'b1);
    repeat (20) @(posedge msoc_clk);
    #2;
    check_flag("uart_tx_o", uart_line, 1'b0);
    write_word(region_addr(msoc_pkg::REG_UART_CTRL, {14'h0, msoc_pkg::UART_BREAK, 2'b00}),
               32'h0, 4'hf);
    check_flag("uart_tx_o", uart_line, 1'b1);
    check_flag("uart_break_o", uart_break, 1'b0);
    end_test("break");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
hdl/msoc_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_ctrl.sv
hdl/data_ram.sv
hdl/bus_ctrl.sv
hdl/msoc_periph.sv
bench/tb_clkgen.sv
bench/tb_msoc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module tb_msoc -f verilog.f -o tb_msoc > build.log 2>&1 \
  && ./obj_dir/tb_msoc > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
